/* dv/adc_ctrl_properties.sv */
/*
 * Protocol assertions for the ADC control top level, attached with bind.
 * Covers the Wishbone ack and the three-wire SPI clock and turnaround.
 */

`timescale 1ns/1ns

`include "adc_ctrl_cfg.svh"

module adc_ctrl_properties (
  input logic core_clk_i,
  input logic rst_n_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic spi_csn_i,
  input logic spi_clk_i,
  input logic sdio_out_i,
  input logic sdio_oe_i
);

  logic csn_q;
  logic rd_sel;

  // The first bit on the line after chip select falls is the read flag
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      csn_q  <= 1'b1;
      rd_sel <= 1'b0;
    end else begin
      csn_q <= spi_csn_i;
      if (csn_q && !spi_csn_i) begin
        rd_sel <= sdio_out_i;
      end
    end
  end

  // ********************************************************
  // Assertions
  // ********************************************************

  ack_with_stb: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    wb_ack_i |-> wb_stb_i) else $error("Wishbone ack seen without strobe");

  // SPI clock stays low between frames
  clk_quiet: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    spi_csn_i |-> !spi_clk_i) else $error("SPI clock active while deselected");

  // High phase of the SPI clock lasts the divider count
  clk_high_time: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    $rose(spi_clk_i) |-> ##(`ADC_CTRL_SPI_DIV) $fell(spi_clk_i))
    else $error("SPI clock high phase has the wrong length");

  // Only a read frame hands the data line to the ADC
  turnaround_rd: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (!spi_csn_i && !sdio_oe_i) |-> rd_sel)
    else $error("Data line released during a write frame");

endmodule

bind adc_ctrl_top adc_ctrl_properties i_properties (
  .core_clk_i (core_clk_i),
  .rst_n_i    (rst_n_i),
  .wb_stb_i   (wb_stb_i),
  .wb_ack_i   (wb_ack_o),
  .spi_csn_i  (spi_csn_o),
  .spi_clk_i  (spi_clk_o),
  .sdio_out_i (spi_sdio_o),
  .sdio_oe_i  (spi_sdio_oe_o)
);

/* dv/adc_ctrl_tb.sv */
/*
 * Testbench for the ADC control top level. A Wishbone master applies a
 * table of register operations while a model of the ADC answers on the
 * three-wire SPI port. SYSREF timing is checked after the table.
 */

`timescale 1ns/1ns

`include "adc_ctrl_cfg.svh"

module adc_ctrl_tb;

  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_POLL  = 2'd2;
  localparam logic [1:0] OP_GPIO  = 2'd3;
  localparam int SYSREF_HALF = `ADC_CTRL_SYSREF_PERIOD / 2;

  // One table entry with the value that its step compares against
  typedef struct packed {
    logic [1:0]  op;
    logic [1:0]  adr;
    logic [31:0] data;
    logic [31:0] expected;
  } step_t;

  logic        core_clk = 1'b0;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic        wb_ack;
  logic [31:0] wb_dat_r;
  logic [7:0]  gpio_in;
  logic [7:0]  gpio_out;
  logic        sysref;
  logic        spi_csn;
  logic        spi_clk;
  logic        spi_sdo;
  logic        spi_oe;
  logic        adc_sdo = 1'b0;
  logic        table_ready = 1'b0;
  step_t       steps[$];
  logic [23:0] frames_exp[$];
  int          frames_sent;

  // ADC model state
  logic [7:0]  adc_regs [0:32767];
  logic [23:0] adc_shift;
  logic [23:0] adc_exp;
  logic [14:0] adc_addr;
  logic [7:0]  adc_out_byte;
  logic        adc_rd = 1'b0;
  int          adc_bits = 0;
  int          frames_done = 0;

  always #50 core_clk = ~core_clk;

  adc_ctrl_top UUT (
    .core_clk_i    (core_clk),
    .rst_n_i       (rst_n),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_we_i       (wb_we),
    .wb_adr_i      (wb_adr),
    .wb_dat_i      (wb_dat_w),
    .wb_ack_o      (wb_ack),
    .wb_dat_o      (wb_dat_r),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .sysref_o      (sysref),
    .spi_csn_o     (spi_csn),
    .spi_clk_o     (spi_clk),
    .spi_sdio_o    (spi_sdo),
    .spi_sdio_oe_o (spi_oe),
    .spi_sdio_i    (adc_sdo)
  );

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  // ********************************************************
  // ADC model
  // ********************************************************

  // Bits are sampled on the rising SPI clock and chip select rising ends a frame
  always @(posedge spi_clk or posedge spi_csn) begin
    if (spi_csn) begin
      if (adc_bits == 24) begin
        if (frames_done >= frames_exp.size()) begin
          $display("The ADC model received a frame that was never issued: %h", adc_shift);
          $display("FAIL: see errors above");
          $fatal(1, "unexpected SPI frame");
        end else begin
          adc_exp = frames_exp[frames_done];
          if (adc_exp[23]) begin
            // Data bits of a read come from the model itself
            check_value({8'h0, adc_shift[23:8], 8'h0}, {8'h0, adc_exp[23:8], 8'h0},
                        "SPI read instruction");
          end else begin
            check_value({8'h0, adc_shift}, {8'h0, adc_exp}, "SPI write frame");
            adc_regs[adc_shift[22:8]] = adc_shift[7:0];
          end
          frames_done++;
        end
      end
      adc_bits = 0;
      adc_rd   = 1'b0;
    end else begin
      adc_shift = {adc_shift[22:0], spi_oe ? spi_sdo : adc_sdo};
      adc_bits++;
      if (adc_bits == 16) begin
        adc_rd   = adc_shift[15];
        adc_addr = adc_shift[14:0];
      end
    end
  end

  // Read data goes out after each falling SPI clock of the data phase
  always @(negedge spi_clk) begin
    #5;
    if (!spi_csn && adc_rd && adc_bits >= 16 && adc_bits < 24) begin
      adc_out_byte = adc_regs[adc_addr];
      adc_sdo      = adc_out_byte[3'(23 - adc_bits)];
    end
  end

  // ********************************************************
  // Bus master and table
  // ********************************************************

  // Holds the request until ack and for the edge that samples it
  task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      @(posedge core_clk);
      #5;
    end while (!wb_ack);
    rdata = wb_dat_r;
    @(posedge core_clk);
    #5;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic add_step(input logic [1:0] op, input logic [1:0] adr,
                          input logic [31:0] data, input logic [31:0] expected);
    steps.push_back({op, adr, data, expected});
  endtask

  task automatic build_table();
    logic [14:0] addr_a;
    logic [14:0] addr_b;
    logic [7:0]  data_a;
    logic [7:0]  data_b;
    addr_a = 15'($urandom);
    addr_b = 15'($urandom);
    if (addr_b == addr_a) begin
      addr_b = addr_a ^ 15'h1;
    end
    data_a = 8'($urandom);
    data_b = 8'($urandom);
    // Reserved bits written high must read back as zero
    add_step(OP_WRITE, `ADC_CTRL_ADDR_CTRL, 32'hFFFF_FFA5, 32'h0000_01A5);
    add_step(OP_READ, `ADC_CTRL_ADDR_CTRL, 32'h0, 32'h0000_01A5);
    add_step(OP_WRITE, `ADC_CTRL_ADDR_CTRL, 32'h0000_005A, 32'h0000_005A);
    add_step(OP_READ, `ADC_CTRL_ADDR_CTRL, 32'h0, 32'h0000_005A);
    // Second write lands while the first frame is still shifting
    add_step(OP_WRITE, `ADC_CTRL_ADDR_SPI_CMD, {8'h0, 1'b0, addr_a, data_a}, 32'h0);
    add_step(OP_WRITE, `ADC_CTRL_ADDR_SPI_CMD, {8'h0, 1'b0, addr_b, data_b}, 32'h0);
    add_step(OP_POLL, `ADC_CTRL_ADDR_SPI_STAT, 32'h0, 32'h0);
    add_step(OP_WRITE, `ADC_CTRL_ADDR_SPI_CMD, {8'h0, 1'b1, addr_a, 8'h00}, 32'h0);
    add_step(OP_POLL, `ADC_CTRL_ADDR_SPI_STAT, 32'h0, {24'h0, data_a});
    add_step(OP_WRITE, `ADC_CTRL_ADDR_SPI_CMD, {8'h0, 1'b1, addr_b, 8'h00}, 32'h0);
    add_step(OP_POLL, `ADC_CTRL_ADDR_SPI_STAT, 32'h0, {24'h0, data_b});
    add_step(OP_GPIO, `ADC_CTRL_ADDR_GPIO_IN, 32'h0000_003C, 32'h0000_003C);
    add_step(OP_GPIO, `ADC_CTRL_ADDR_GPIO_IN, 32'h0000_00C3, 32'h0000_00C3);
  endtask

  task automatic apply_step(input step_t s);
    logic [31:0] rdata;
    case (s.op)
      OP_WRITE: begin
        if (s.adr == `ADC_CTRL_ADDR_SPI_CMD) begin
          frames_exp.push_back(s.data[23:0]);
        end
        bus_access(1'b1, s.adr, s.data, rdata);
        // Every earlier frame must be finished before a new one is acked
        if (s.adr == `ADC_CTRL_ADDR_SPI_CMD) begin
          check_value(32'(frames_done), 32'(frames_sent), "frames done at SPI_CMD ack");
          frames_sent++;
        end
        if (s.adr == `ADC_CTRL_ADDR_CTRL) begin
          check_value({24'h0, gpio_out}, {24'h0, s.expected[7:0]},
                      "gpio_o after CTRL write");
        end
      end
      OP_READ: begin
        bus_access(1'b0, s.adr, 32'h0, rdata);
        check_value(rdata, s.expected, "register read");
      end
      OP_POLL: begin
        do begin
          bus_access(1'b0, s.adr, 32'h0, rdata);
        end while (rdata[31]);
        check_value(rdata, s.expected, "SPI_STAT after frame");
      end
      default: begin
        gpio_in = s.data[7:0];
        // Two synchronizer flops plus margin
        repeat (3) @(posedge core_clk);
        #5;
        bus_access(1'b0, s.adr, 32'h0, rdata);
        check_value(rdata, s.expected, "GPIO_IN read");
      end
    endcase
  endtask

  task automatic check_sysref();
    logic [31:0] rdata;
    int          run;
    bus_access(1'b1, `ADC_CTRL_ADDR_CTRL, 32'h0000_0100, rdata);
    while (!sysref) begin
      @(posedge core_clk);
      #5;
    end
    repeat (3) begin
      run = 0;
      while (sysref) begin
        run++;
        @(posedge core_clk);
        #5;
      end
      check_value(32'(run), 32'(SYSREF_HALF), "SYSREF high time");
      run = 0;
      while (!sysref) begin
        run++;
        @(posedge core_clk);
        #5;
      end
      check_value(32'(run), 32'(SYSREF_HALF), "SYSREF low time");
    end
    bus_access(1'b1, `ADC_CTRL_ADDR_CTRL, 32'h0, rdata);
    repeat (`ADC_CTRL_SYSREF_PERIOD) begin
      check_value({31'h0, sysref}, 32'h0, "SYSREF after disable");
      @(posedge core_clk);
      #5;
    end
  endtask

  // ********************************************************
  // Watchdog and main sequence
  // ********************************************************

  initial begin
    int limit;
    wait (table_ready);
    limit = steps.size() * (48 * `ADC_CTRL_SPI_DIV + 20) + 8 * `ADC_CTRL_SYSREF_PERIOD + 40;
    repeat (limit) @(posedge core_clk);
    $display("Timeout: the tests were still running after %0d clocks", limit);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h5731_1692));
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = 2'd0;
    wb_dat_w    = 32'h0;
    gpio_in     = 8'h0;
    frames_sent = 0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge core_clk);
    #5;
    // Ack, SPI clock, SYSREF, output enable and GPIO are low and chip select is high
    check_value({20'h0, wb_ack, spi_clk, sysref, spi_oe, gpio_out},
                32'h0, "outputs in reset");
    check_value({31'h0, spi_csn}, 32'h1, "chip select in reset");
    rst_n = 1'b1;
    @(posedge core_clk);
    #5;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    check_sysref();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
hdl/adc_ctrl_pkg.sv
hdl/spi_frame_pkg.sv
hdl/spi_cmd_if.sv
hdl/wb_reg_file.sv
hdl/spi_3wire_engine.sv
hdl/sysref_gen.sv
hdl/adc_ctrl_top.sv
dv/adc_ctrl_properties.sv
dv/adc_ctrl_tb.sv

/* hdl/adc_ctrl_pkg.sv */
/*
 * Register map types of the ADC control subsystem. The register index
 * follows the word addresses of the configuration header.
 */

`include "adc_ctrl_cfg.svh"

package adc_ctrl_pkg;

  // ********************************************************
  // Register index
  // ********************************************************

  // One name per Wishbone word address
  typedef enum logic [1:0] {
    REG_CTRL     = `ADC_CTRL_ADDR_CTRL,
    REG_SPI_CMD  = `ADC_CTRL_ADDR_SPI_CMD,
    REG_SPI_STAT = `ADC_CTRL_ADDR_SPI_STAT,
    REG_GPIO_IN  = `ADC_CTRL_ADDR_GPIO_IN
  } reg_idx_e;

  // ********************************************************
  // Control register
  // ********************************************************

  // Bits 7:0 drive the GPIO outputs
  // Bit 8 enables the SYSREF generator
  // The upper bits read back as zero
  typedef struct packed {
    logic [22:0] rsvd;
    logic        sysref_en;
    logic [7:0]  gpio_out;
  } ctrl_reg_t;

endpackage

/* hdl/adc_ctrl_top.sv */
/*
 * Converter control subsystem top. Wishbone register stage feeding the
 * SPI shift stage, with the SYSREF generator alongside. The SPI data line
 * comes out as in, out and enable; the board wrapper adds the tristate.
 */

`timescale 1ns/1ns

module adc_ctrl_top (
  input  logic        core_clk_i,
  input  logic        rst_n_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic        wb_ack_o,
  output logic [31:0] wb_dat_o,
  input  logic [7:0]  gpio_i,
  output logic [7:0]  gpio_o,
  output logic        sysref_o,
  output logic        spi_csn_o,
  output logic        spi_clk_o,
  output logic        spi_sdio_o,
  output logic        spi_sdio_oe_o,
  input  logic        spi_sdio_i
);

  logic sysref_en;

  // Frame path between the two pipeline stages
  spi_cmd_if spi_cmd ();

  wb_reg_file i_wb_reg_file (
    .core_clk_i  (core_clk_i),
    .rst_n_i     (rst_n_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_o    (wb_ack_o),
    .wb_dat_o    (wb_dat_o),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .sysref_en_o (sysref_en),
    .spi_cmd     (spi_cmd.reg_mp));

  spi_3wire_engine i_spi_3wire_engine (
    .core_clk_i    (core_clk_i),
    .rst_n_i       (rst_n_i),
    .spi_cmd       (spi_cmd.eng_mp),
    .spi_csn_o     (spi_csn_o),
    .spi_clk_o     (spi_clk_o),
    .spi_sdio_o    (spi_sdio_o),
    .spi_sdio_oe_o (spi_sdio_oe_o),
    .spi_sdio_i    (spi_sdio_i));

  // Sits beside the pipeline, driven only by the control register
  sysref_gen i_sysref_gen (
    .core_clk_i  (core_clk_i),
    .rst_n_i     (rst_n_i),
    .sysref_en_i (sysref_en),
    .sysref_o    (sysref_o));

endmodule

/* hdl/spi_3wire_engine.sv */
/*
 * Three-wire SPI master for the ADC configuration port. It shifts one
 * 24-bit frame MSB first and, for a read frame, releases the shared data
 * line after the instruction phase to capture the 8 data bits.
 */

`timescale 1ns/1ns

`include "adc_ctrl_cfg.svh"

module spi_3wire_engine (
  input  logic      core_clk_i,
  input  logic      rst_n_i,
  spi_cmd_if.eng_mp spi_cmd,
  output logic      spi_csn_o,
  output logic      spi_clk_o,
  output logic      spi_sdio_o,
  output logic      spi_sdio_oe_o,
  input  logic      spi_sdio_i
);
  import spi_frame_pkg::*;

  // State encoding
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_SHIFT  = 2'd1;
  localparam logic [1:0] ST_FINISH = 2'd2;

  // Divider counter wide enough for a divider of one
  localparam int DIV_W = ($clog2(`ADC_CTRL_SPI_DIV) > 0) ? $clog2(`ADC_CTRL_SPI_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`ADC_CTRL_SPI_DIV - 1);

  localparam int BIT_W = $clog2(SPI_FRAME_BITS);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(SPI_FRAME_BITS - 1);
  // Last instruction bit, the line turns around after it
  localparam logic [BIT_W-1:0] TURN_BIT = BIT_W'(SPI_FRAME_BITS - SPI_DATA_BITS - 1);

  logic [1:0]                state;
  logic [DIV_W-1:0]          div_cnt;
  logic [BIT_W-1:0]          bit_cnt;
  logic                      rd_frame;
  logic                      accept;
  logic                      sclk_rise;
  logic                      sclk_fall;
  logic [SPI_FRAME_BITS-1:0] tx_shift;
  logic [SPI_DATA_BITS-1:0]  rx_shift;

  assign spi_cmd.frame_ready = (state == ST_IDLE);
  assign accept = spi_cmd.frame_valid & spi_cmd.frame_ready;

  // SPI clock edges happen when the divider wraps
  assign sclk_rise = (state == ST_SHIFT) && (div_cnt == DIV_LAST) && !spi_clk_o;
  assign sclk_fall = (state == ST_SHIFT) && (div_cnt == DIV_LAST) && spi_clk_o;

  // ********************************************************
  // Frame sequencer
  // ********************************************************

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state         <= ST_IDLE;
      div_cnt       <= '0;
      bit_cnt       <= '0;
      rd_frame      <= 1'b0;
      spi_csn_o     <= 1'b1;
      spi_clk_o     <= 1'b0;
      spi_sdio_o    <= 1'b0;
      spi_sdio_oe_o <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            // Select the ADC and put the first bit on the line
            state         <= ST_SHIFT;
            div_cnt       <= '0;
            bit_cnt       <= '0;
            rd_frame      <= spi_cmd.frame.fields.rd_nwr;
            spi_csn_o     <= 1'b0;
            spi_sdio_o    <= spi_cmd.frame.raw[SPI_FRAME_BITS-1];
            spi_sdio_oe_o <= 1'b1;
          end
        end
        ST_SHIFT: begin
          if (div_cnt == DIV_LAST) begin
            div_cnt   <= '0;
            spi_clk_o <= ~spi_clk_o;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
          if (sclk_fall) begin
            if (bit_cnt == BIT_LAST) begin
              // Last period done, deselect and release the line
              state         <= ST_FINISH;
              spi_csn_o     <= 1'b1;
              spi_sdio_o    <= 1'b0;
              spi_sdio_oe_o <= 1'b0;
            end else begin
              bit_cnt    <= bit_cnt + 1'b1;
              spi_sdio_o <= tx_shift[SPI_FRAME_BITS-2];
              // The ADC drives the data phase of a read
              if (rd_frame && bit_cnt == TURN_BIT) begin
                spi_sdio_oe_o <= 1'b0;
              end
            end
          end
        end
        ST_FINISH: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ********************************************************
  // Shift registers
  // ********************************************************

  // Data changes on the falling edge and is sampled on the rising edge
  always_ff @(posedge core_clk_i) begin
    if (accept) begin
      tx_shift <= spi_cmd.frame.raw;
    end else if (sclk_fall) begin
      tx_shift <= tx_shift << 1;
    end
    // Only the last 8 samples of a read are kept
    if (sclk_rise) begin
      rx_shift <= {rx_shift[SPI_DATA_BITS-2:0], spi_sdio_i};
    end
  end

  assign spi_cmd.rd_done = (state == ST_FINISH);
  assign spi_cmd.rd_data = rd_frame ? rx_shift : '0;

endmodule

/* hdl/spi_cmd_if.sv */
/*
 * Frame request and read result path from the Wishbone register stage to
 * the SPI shift stage. The register side owns the request, the engine
 * side owns the handshake back and the read byte.
 */

`timescale 1ns/1ns

interface spi_cmd_if;
  import spi_frame_pkg::*;

  // Request, transfers when valid and ready are both high
  logic                     frame_valid;
  spi_frame_u               frame;
  logic                     frame_ready;

  // One cycle pulse at the end of every frame, zero byte for writes
  logic [SPI_DATA_BITS-1:0] rd_data;
  logic                     rd_done;

  modport reg_mp (output frame_valid, frame, input frame_ready, rd_data, rd_done);
  modport eng_mp (input frame_valid, frame, output frame_ready, rd_data, rd_done);

endinterface

/* hdl/spi_frame_pkg.sv */
/*
 * Types of the 24-bit SPI configuration frame. A frame is seen either as
 * the raw word that is shifted out or as its decoded instruction fields.
 */

package spi_frame_pkg;

  // Whole frame and its data phase, in bits
  localparam int SPI_FRAME_BITS = 24;
  localparam int SPI_DATA_BITS  = 8;

  // Instruction phase first, data byte last
  typedef struct packed {
    logic        rd_nwr;
    logic [14:0] addr;
    logic [7:0]  data;
  } spi_fields_t;

  // Same frame word, shift view and field view
  typedef union packed {
    logic [SPI_FRAME_BITS-1:0] raw;
    spi_fields_t               fields;
  } spi_frame_u;

endpackage

/* hdl/sysref_gen.sv */
/*
 * Periodic SYSREF source for the JESD204 ADC. While enabled it produces
 * a square wave of the configured period, otherwise it holds low.
 */

`timescale 1ns/1ns

`include "adc_ctrl_cfg.svh"

module sysref_gen (
  input  logic core_clk_i,
  input  logic rst_n_i,
  input  logic sysref_en_i,
  output logic sysref_o
);

  // Half period sets the time between toggles
  localparam int HALF   = `ADC_CTRL_SYSREF_PERIOD / 2;
  localparam int CNT_W  = ($clog2(HALF) > 0) ? $clog2(HALF) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF - 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt      <= '0;
      sysref_o <= 1'b0;
    end else if (!sysref_en_i) begin
      // Disabled, restart from a clean low phase
      cnt      <= '0;
      sysref_o <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt      <= '0;
      sysref_o <= ~sysref_o;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* hdl/wb_reg_file.sv */
/*
 * Wishbone classic slave with the control, SPI command, SPI status and
 * GPIO input registers. A write to SPI_CMD hands the frame to the SPI
 * engine and is acked only once the engine has taken it.
 */

`timescale 1ns/1ns

module wb_reg_file (
  input  logic        core_clk_i,
  input  logic        rst_n_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic        wb_ack_o,
  output logic [31:0] wb_dat_o,
  input  logic [7:0]  gpio_i,
  output logic [7:0]  gpio_o,
  output logic        sysref_en_o,
  spi_cmd_if.reg_mp   spi_cmd
);
  import adc_ctrl_pkg::*;
  import spi_frame_pkg::*;

  reg_idx_e                  adr_idx;
  logic                      wb_req;
  logic                      cmd_wr;
  logic                      ack_next;
  ctrl_reg_t                 ctrl_q;
  ctrl_reg_t                 ctrl_wr;
  spi_frame_u                cmd_frame;
  logic [SPI_FRAME_BITS-1:0] last_frame;
  logic                      busy;
  logic [SPI_DATA_BITS-1:0]  rd_byte;
  logic [7:0]                gpio_meta;
  logic [7:0]                gpio_sync;
  logic [31:0]               rd_mux;

  // ********************************************************
  // Bus decode
  // ********************************************************

  assign adr_idx = reg_idx_e'(wb_adr_i);

  // A request is new until its ack has gone out
  assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign cmd_wr = wb_req & wb_we_i & (adr_idx == REG_SPI_CMD);

  // Everything acks on the next clock except a frame the engine cannot take yet
  assign ack_next = wb_req & (~cmd_wr | spi_cmd.frame_ready);

  // The frame comes straight off the bus, low 24 bits
  assign cmd_frame.raw     = wb_dat_i[SPI_FRAME_BITS-1:0];
  assign spi_cmd.frame     = cmd_frame;
  assign spi_cmd.frame_valid = cmd_wr;

  // Reserved control bits are never stored
  always_comb begin
    ctrl_wr      = ctrl_reg_t'(wb_dat_i);
    ctrl_wr.rsvd = '0;
  end

  // ********************************************************
  // Registers
  // ********************************************************

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_o   <= 1'b0;
      ctrl_q     <= '0;
      last_frame <= '0;
      busy       <= 1'b0;
      rd_byte    <= '0;
      gpio_meta  <= '0;
      gpio_sync  <= '0;
    end else begin
      wb_ack_o <= ack_next;
      if (ack_next && wb_we_i && adr_idx == REG_CTRL) begin
        ctrl_q <= ctrl_wr;
      end
      // Busy runs from acceptance until the engine reports the end
      if (cmd_wr && spi_cmd.frame_ready) begin
        last_frame <= cmd_frame.raw;
        busy       <= 1'b1;
      end else if (spi_cmd.rd_done) begin
        busy <= 1'b0;
      end
      if (spi_cmd.rd_done) begin
        rd_byte <= spi_cmd.rd_data;
      end
      // Two flop synchronizer for the board inputs
      gpio_meta <= gpio_i;
      gpio_sync <= gpio_meta;
    end
  end

  // Read data for the addressed register
  always_comb begin
    case (adr_idx)
      REG_CTRL:     rd_mux = ctrl_q;
      REG_SPI_CMD:  rd_mux = {{(32 - SPI_FRAME_BITS){1'b0}}, last_frame};
      REG_SPI_STAT: rd_mux = {busy, {(31 - SPI_DATA_BITS){1'b0}}, rd_byte};
      default:      rd_mux = {24'h0, gpio_sync};
    endcase
  end

  // Read word is captured with the ack
  always_ff @(posedge core_clk_i) begin
    if (ack_next && !wb_we_i) begin
      wb_dat_o <= rd_mux;
    end
  end

  assign gpio_o      = ctrl_q.gpio_out;
  assign sysref_en_o = ctrl_q.sysref_en;

endmodule

/* include/adc_ctrl_cfg.svh */
/*
 * Build-time configuration of the ADC control subsystem: SYSREF period,
 * SPI clock divider and the Wishbone register map. Include it wherever
 * one of these values is needed.
 */

`ifndef ADC_CTRL_CFG_SVH
`define ADC_CTRL_CFG_SVH

// SYSREF period in core clocks, must be even, high for half of it
`define ADC_CTRL_SYSREF_PERIOD 64

// Core clocks per half period of the SPI clock
`define ADC_CTRL_SPI_DIV 4

// Word addresses of the register map
`define ADC_CTRL_ADDR_CTRL     2'd0
`define ADC_CTRL_ADDR_SPI_CMD  2'd1
`define ADC_CTRL_ADDR_SPI_STAT 2'd2
`define ADC_CTRL_ADDR_GPIO_IN  2'd3

`endif

/* run_sim.sh */
#!/bin/sh
# Builds the ADC control testbench with Verilator and runs it.
# Exits non-zero on a build error, a simulator error or a missing pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f flist.f --top-module adc_ctrl_tb -Mdir obj_dir -o adc_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/adc_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
